// ==== design/csr_pkg.sv ====
/*
 * CSR slice package
 * Widths, machine-mode CSR addresses, the CSR operation encoding
 * and the writable-bit masks shared by the CSR execute slice
 */
`default_nettype none

package csr_pkg;

	localparam int XLEN    = 64;                      // Integer data width
	localparam int CSR_AW  = 12;                      // CSR address width
	localparam int PRF_NUM = 64;                      // Physical integer registers
	localparam int PRF_AW  = $clog2(PRF_NUM);         // Physical register tag width
	localparam int IMM_W   = 5;                       // Immediate field of CSRRWI/CSRRSI/CSRRCI

	// Encoding 0 is left unused so an idle opcode field never writes
	typedef enum logic [1:0] {
		CSR_RW = 2'd1,                                // CSRRW and CSRRWI
		CSR_RS = 2'd2,                                // CSRRS and CSRRSI
		CSR_RC = 2'd3                                 // CSRRC and CSRRCI
	} csr_op_t;

	localparam logic [CSR_AW-1:0] ADDR_MSTATUS  = 12'h300;  // Machine status
	localparam logic [CSR_AW-1:0] ADDR_MISA     = 12'h301;  // ISA and extensions
	localparam logic [CSR_AW-1:0] ADDR_MTVEC    = 12'h305;  // Trap vector base
	localparam logic [CSR_AW-1:0] ADDR_MSCRATCH = 12'h340;  // Scratch register
	localparam logic [CSR_AW-1:0] ADDR_MEPC     = 12'h341;  // Exception PC
	localparam logic [CSR_AW-1:0] ADDR_MCAUSE   = 12'h342;  // Trap cause
	localparam logic [CSR_AW-1:0] ADDR_MCYCLE   = 12'hB00;  // Cycle counter

	// Only MIE (bit 3) and MPIE (bit 7) can be written in mstatus
	localparam logic [XLEN-1:0] MSTATUS_WMASK = 64'h0000_0000_0000_0088;

	// Direct mode only, so the MODE bits of mtvec stay zero
	localparam logic [XLEN-1:0] MTVEC_WMASK   = 64'hFFFF_FFFF_FFFF_FFFC;

	// Instructions are at least 16-bit aligned
	localparam logic [XLEN-1:0] MEPC_WMASK    = 64'hFFFF_FFFF_FFFF_FFFE;

	// MXL = 2 marks RV64, bit 8 is the I extension
	localparam logic [XLEN-1:0] MISA_VALUE    = 64'h8000_0000_0000_0100;

endpackage

`default_nettype wire

// ==== design/csr_file.sv ====
/*
 * Machine-mode CSR file
 * Combinational read, write at the clock edge through per-register
 * masks, and a free-running 64-bit cycle counter
 */
`default_nettype none

module csr_file (
	input  wire                         CLK,
	input  wire                         rst,
	input  wire  [csr_pkg::CSR_AW-1:0]  csr_addr,
	input  wire                         csr_wen,
	input  wire  [csr_pkg::XLEN-1:0]    csr_wdata,
	output logic [csr_pkg::XLEN-1:0]    csr_rdata
);

	logic [csr_pkg::XLEN-1:0] mstatus;                // Only MIE and MPIE ever become set
	logic [csr_pkg::XLEN-1:0] mtvec;                  // Low two bits stay zero
	logic [csr_pkg::XLEN-1:0] mscratch;               // Fully writable
	logic [csr_pkg::XLEN-1:0] mepc;                   // Bit 0 stays zero
	logic [csr_pkg::XLEN-1:0] mcause;                 // Fully writable
	logic [csr_pkg::XLEN-1:0] mcycle;                 // Counts every clock

	logic                     mcycle_wr;              // A write to mcycle this cycle

	assign mcycle_wr = csr_wen && (csr_addr == csr_pkg::ADDR_MCYCLE);

	// Read mux, misa is a constant and unknown addresses return zero
	always_comb begin
		case (csr_addr)
			csr_pkg::ADDR_MSTATUS:  csr_rdata = mstatus;
			csr_pkg::ADDR_MISA:     csr_rdata = csr_pkg::MISA_VALUE;
			csr_pkg::ADDR_MTVEC:    csr_rdata = mtvec;
			csr_pkg::ADDR_MSCRATCH: csr_rdata = mscratch;
			csr_pkg::ADDR_MEPC:     csr_rdata = mepc;
			csr_pkg::ADDR_MCAUSE:   csr_rdata = mcause;
			csr_pkg::ADDR_MCYCLE:   csr_rdata = mcycle;
			default:                csr_rdata = '0;
		endcase
	end

	// Writes go through the mask of their register, misa and unknown addresses drop them
	always_ff @(posedge CLK) begin
		if (rst) begin
			mstatus  <= '0;
			mtvec    <= '0;
			mscratch <= '0;
			mepc     <= '0;
			mcause   <= '0;
		end else if (csr_wen) begin
			case (csr_addr)
				csr_pkg::ADDR_MSTATUS: begin
					mstatus <= csr_wdata & csr_pkg::MSTATUS_WMASK;  // Other fields read zero
				end
				csr_pkg::ADDR_MTVEC: begin
					mtvec <= csr_wdata & csr_pkg::MTVEC_WMASK;      // Direct mode only
				end
				csr_pkg::ADDR_MSCRATCH: begin
					mscratch <= csr_wdata;
				end
				csr_pkg::ADDR_MEPC: begin
					mepc <= csr_wdata & csr_pkg::MEPC_WMASK;        // Keep the PC aligned
				end
				csr_pkg::ADDR_MCAUSE: begin
					mcause <= csr_wdata;
				end
				default: begin
					mstatus <= mstatus;                             // Ignored write
				end
			endcase
		end
	end

	// A write replaces the count for that cycle instead of adding one
	always_ff @(posedge CLK) begin
		if (rst) begin
			mcycle <= '0;
		end else if (mcycle_wr) begin
			mcycle <= csr_wdata;
		end else begin
			mcycle <= mcycle + 1'b1;                  // Wraps silently at 2^64
		end
	end

endmodule

`default_nettype wire

// ==== design/csr_arbiter.sv ====
/*
 * CSR port arbiter
 * Puts the debug port or the execute unit onto the single CSR-file
 * port, debug first, and returns the debug read one cycle later
 */
`default_nettype none

module csr_arbiter (
	input  wire                         CLK,
	input  wire                         rst,
	input  wire                         exe_req,
	input  wire  [csr_pkg::CSR_AW-1:0]  exe_addr,
	input  wire                         exe_wen,
	input  wire  [csr_pkg::XLEN-1:0]    exe_wdata,
	output logic                        exe_gnt,
	output logic [csr_pkg::XLEN-1:0]    exe_rdata,
	input  wire                         dbg_valid,
	output logic                        dbg_ready,
	input  wire  [csr_pkg::CSR_AW-1:0]  dbg_addr,
	input  wire                         dbg_wen,
	input  wire  [csr_pkg::XLEN-1:0]    dbg_wdata,
	output logic                        dbg_rsp_valid,
	output logic [csr_pkg::XLEN-1:0]    dbg_rdata,
	output logic [csr_pkg::CSR_AW-1:0]  csr_addr,
	output logic                        csr_wen,
	output logic [csr_pkg::XLEN-1:0]    csr_wdata,
	input  wire  [csr_pkg::XLEN-1:0]    csr_rdata
);

	assign dbg_ready = dbg_valid;                     // Debug always wins, so it never waits
	assign exe_gnt   = ~dbg_valid;                    // Execute unit owns the port otherwise

	// Request mux onto the CSR file
	assign csr_addr  = dbg_valid ? dbg_addr  : exe_addr;
	assign csr_wdata = dbg_valid ? dbg_wdata : exe_wdata;
	assign csr_wen   = dbg_valid ? dbg_wen   : (exe_req & exe_wen);

	assign exe_rdata = csr_rdata;                     // Only meaningful while exe_gnt is high

	// Response valid follows each debug transfer by one cycle
	always_ff @(posedge CLK) begin
		if (rst) begin
			dbg_rsp_valid <= 1'b0;
		end else begin
			dbg_rsp_valid <= dbg_valid;
		end
	end

	// Capture the value from before any debug write lands
	always_ff @(posedge CLK) begin
		if (dbg_valid) begin
			dbg_rdata <= csr_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== design/csr_exe.sv ====
/*
 * CSR execute unit
 * Decodes the issue packet, selects the register or immediate operand,
 * forms the read-modify-write value and registers the writeback
 */
`default_nettype none

module csr_exe (
	input  wire                         CLK,
	input  wire                         rst,
	input  wire                         flush,
	input  wire                         issue_valid,
	output logic                        issue_ready,
	input  wire  csr_pkg::csr_op_t      issue_op,
	input  wire                         issue_imm,
	input  wire  [csr_pkg::PRF_AW-1:0]  issue_rs1,
	input  wire  [csr_pkg::PRF_AW-1:0]  issue_rd,
	input  wire  [csr_pkg::CSR_AW-1:0]  issue_addr,
	output logic [csr_pkg::PRF_AW-1:0]  rs_tag,
	input  wire  [csr_pkg::XLEN-1:0]    rs_data,
	output logic                        exe_req,
	output logic [csr_pkg::CSR_AW-1:0]  exe_addr,
	output logic                        exe_wen,
	output logic [csr_pkg::XLEN-1:0]    exe_wdata,
	input  wire                         exe_gnt,
	input  wire  [csr_pkg::XLEN-1:0]    exe_rdata,
	output logic                        wb_valid,
	output logic [csr_pkg::PRF_AW-1:0]  wb_rd,
	output logic [csr_pkg::XLEN-1:0]    wb_data
);

	logic                     fire;                   // Issue transfer this cycle
	logic [csr_pkg::XLEN-1:0] operand;                // rs1 value or zero-extended immediate
	logic [csr_pkg::XLEN-1:0] new_val;                // Value written back to the CSR
	logic                     do_write;               // Operation really changes the CSR
	logic                     wb_valid_q;             // Writeback pending for the next cycle

	assign issue_ready = exe_gnt;                     // Stalls only while debug holds the port
	assign fire        = issue_valid & issue_ready;

	// Source read is combinational, the immediate sits in the low bits of rs1
	assign rs_tag  = issue_rs1;
	assign operand = issue_imm ?
		{{(csr_pkg::XLEN - csr_pkg::IMM_W){1'b0}}, issue_rs1[csr_pkg::IMM_W-1:0]} : rs_data;

	// Set and clear with a zero operand leave the CSR untouched and make no write
	always_comb begin
		case (issue_op)
			csr_pkg::CSR_RW: begin
				new_val  = operand;
				do_write = 1'b1;
			end
			csr_pkg::CSR_RS: begin
				new_val  = exe_rdata | operand;
				do_write = (operand != '0);
			end
			csr_pkg::CSR_RC: begin
				new_val  = exe_rdata & ~operand;
				do_write = (operand != '0);
			end
			default: begin
				new_val  = exe_rdata;             // Unused encoding reads only
				do_write = 1'b0;
			end
		endcase
	end

	// Request to the arbiter, the write happens at the edge that ends the transfer
	assign exe_req   = issue_valid;
	assign exe_addr  = issue_addr;
	assign exe_wen   = fire & do_write;
	assign exe_wdata = new_val;

	// rd of zero produces no writeback, a flush drops the instruction in flight
	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= fire & (issue_rd != '0) & ~flush;
		end
	end

	// Old CSR value and destination tag
	always_ff @(posedge CLK) begin
		if (fire) begin
			wb_rd   <= issue_rd;
			wb_data <= exe_rdata;                     // Value from before the update
		end
	end

	// Flush in the writeback cycle still cancels it, the CSR write already happened
	assign wb_valid = wb_valid_q & ~flush;

endmodule

`default_nettype wire

// ==== design/phy_regfile.sv ====
/*
 * Physical integer register file
 * One combinational read port for the CSR source, a writeback port and
 * a preload port, register 0 is hard-wired to zero
 */
`default_nettype none

module phy_regfile (
	input  wire                         CLK,
	input  wire                         rst,
	input  wire  [csr_pkg::PRF_AW-1:0]  rs_tag,
	output logic [csr_pkg::XLEN-1:0]    rs_data,
	input  wire                         wb_valid,
	input  wire  [csr_pkg::PRF_AW-1:0]  wb_rd,
	input  wire  [csr_pkg::XLEN-1:0]    wb_data,
	input  wire                         pre_valid,
	input  wire  [csr_pkg::PRF_AW-1:0]  pre_tag,
	input  wire  [csr_pkg::XLEN-1:0]    pre_data
);

	logic [csr_pkg::XLEN-1:0] regs [csr_pkg::PRF_NUM];  // Entry 0 is never read back

	logic                     wb_we;                  // Writeback write enable
	logic                     pre_we;                 // Preload write enable

	// No writes land while reset is held, tag 0 is never written
	assign wb_we  = ~rst & wb_valid  & (wb_rd   != '0);
	assign pre_we = ~rst & pre_valid & (pre_tag != '0);

	// Tag 0 reads zero whatever the array holds
	always_comb begin
		if (rs_tag == '0) begin
			rs_data = '0;
		end else begin
			rs_data = regs[rs_tag];
		end
	end

	// Preload first, so a writeback to the same tag overrides it
	always_ff @(posedge CLK) begin
		if (pre_we) begin
			regs[pre_tag] <= pre_data;
		end
		if (wb_we) begin
			regs[wb_rd] <= wb_data;                   // Writeback wins on a tag clash
		end
	end

endmodule

`default_nettype wire

// ==== design/csr_unit_top.sv ====
/*
 * CSR execution slice top level
 * Wires the register file, the CSR execute unit, the port arbiter
 * and the machine-mode CSR file together
 */
`default_nettype none

module csr_unit_top (
	input  wire                         CLK,
	input  wire                         rst,
	input  wire                         flush,
	input  wire                         issue_valid,
	output logic                        issue_ready,
	input  wire  csr_pkg::csr_op_t      issue_op,
	input  wire                         issue_imm,
	input  wire  [csr_pkg::PRF_AW-1:0]  issue_rs1,
	input  wire  [csr_pkg::PRF_AW-1:0]  issue_rd,
	input  wire  [csr_pkg::CSR_AW-1:0]  issue_addr,
	input  wire                         pre_valid,
	input  wire  [csr_pkg::PRF_AW-1:0]  pre_tag,
	input  wire  [csr_pkg::XLEN-1:0]    pre_data,
	input  wire                         dbg_valid,
	output logic                        dbg_ready,
	input  wire  [csr_pkg::CSR_AW-1:0]  dbg_addr,
	input  wire                         dbg_wen,
	input  wire  [csr_pkg::XLEN-1:0]    dbg_wdata,
	output logic                        dbg_rsp_valid,
	output logic [csr_pkg::XLEN-1:0]    dbg_rdata,
	output logic                        wb_valid,
	output logic [csr_pkg::PRF_AW-1:0]  wb_rd,
	output logic [csr_pkg::XLEN-1:0]    wb_data
);

	logic [csr_pkg::PRF_AW-1:0] rs_tag;               // Source tag from the execute unit
	logic [csr_pkg::XLEN-1:0]   rs_data;              // Source value from the register file
	logic                       exe_req;              // Execute unit wants the CSR port
	logic [csr_pkg::CSR_AW-1:0] exe_addr;
	logic                       exe_wen;
	logic [csr_pkg::XLEN-1:0]   exe_wdata;
	logic                       exe_gnt;              // Low while debug owns the port
	logic [csr_pkg::XLEN-1:0]   exe_rdata;
	logic [csr_pkg::CSR_AW-1:0] csr_addr;             // Arbitrated CSR-file port
	logic                       csr_wen;
	logic [csr_pkg::XLEN-1:0]   csr_wdata;
	logic [csr_pkg::XLEN-1:0]   csr_rdata;

	phy_regfile u_prf (
		.CLK(CLK), .rst(rst), .rs_tag(rs_tag), .rs_data(rs_data),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),  // Old CSR value lands in rd
		.pre_valid(pre_valid), .pre_tag(pre_tag), .pre_data(pre_data)
	);

	csr_exe u_exe (
		.CLK(CLK), .rst(rst), .flush(flush),
		.issue_valid(issue_valid), .issue_ready(issue_ready), .issue_op(issue_op),
		.issue_imm(issue_imm), .issue_rs1(issue_rs1), .issue_rd(issue_rd),
		.issue_addr(issue_addr), .rs_tag(rs_tag), .rs_data(rs_data),
		.exe_req(exe_req), .exe_addr(exe_addr), .exe_wen(exe_wen), .exe_wdata(exe_wdata),
		.exe_gnt(exe_gnt), .exe_rdata(exe_rdata),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	csr_arbiter u_arb (
		.CLK(CLK), .rst(rst),
		.exe_req(exe_req), .exe_addr(exe_addr), .exe_wen(exe_wen), .exe_wdata(exe_wdata),
		.exe_gnt(exe_gnt), .exe_rdata(exe_rdata),
		.dbg_valid(dbg_valid), .dbg_ready(dbg_ready), .dbg_addr(dbg_addr),
		.dbg_wen(dbg_wen), .dbg_wdata(dbg_wdata),
		.dbg_rsp_valid(dbg_rsp_valid), .dbg_rdata(dbg_rdata),
		.csr_addr(csr_addr), .csr_wen(csr_wen), .csr_wdata(csr_wdata), .csr_rdata(csr_rdata)
	);

	csr_file u_csr (
		.CLK(CLK), .rst(rst), .csr_addr(csr_addr), .csr_wen(csr_wen),
		.csr_wdata(csr_wdata), .csr_rdata(csr_rdata)
	);

endmodule

`default_nettype wire

// ==== verif/clk_gen.sv ====
/*
 * Testbench clock generator
 * Free-running clock that starts low
 */
`default_nettype none

module clk_gen #(
	parameter int PERIOD = 100                        // Full clock period in time units
) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
	end

	always #(PERIOD / 2) CLK = ~CLK;                 // First rising edge at half a period

endmodule

`default_nettype wire

// ==== verif/tb_csr_unit.sv ====
/*
 * Testbench for the CSR execution slice
 * Directed tests checked against a model of the CSRs and the register file
 */
`default_nettype none

module tb_csr_unit;

	localparam int PERIOD      = 100;                 // Clock period
	localparam int SETTLE      = PERIOD / 4;          // Sample point after a falling edge
	localparam int RESET_CYC   = 5;
	localparam int IDLE_GAP    = 3;                   // Cycles between the two mcycle reads
	localparam int STALL_LIMIT = 20;                  // Longest wait for issue_ready
	localparam int TEST_CYC    = 5 + 31 + 30 + 34 + 7 + 5 + 27;  // Reset and each test in order
	localparam int MARGIN      = 4;
	localparam logic [31:0] SEED = 32'h62cb;
	localparam logic [csr_pkg::CSR_AW-1:0] ADDR_UNKNOWN = 12'h7C0;   // Not implemented
	localparam logic [csr_pkg::XLEN-1:0]   MCYCLE_STEP  = IDLE_GAP + 2;  // Edges between reads

	logic                         CLK;
	logic                         rst;
	logic                         flush;
	logic                         issue_valid;
	logic                         issue_ready;
	csr_pkg::csr_op_t             issue_op;
	logic                         issue_imm;
	logic [csr_pkg::PRF_AW-1:0]   issue_rs1;
	logic [csr_pkg::PRF_AW-1:0]   issue_rd;
	logic [csr_pkg::CSR_AW-1:0]   issue_addr;
	logic                         pre_valid;
	logic [csr_pkg::PRF_AW-1:0]   pre_tag;
	logic [csr_pkg::XLEN-1:0]     pre_data;
	logic                         dbg_valid;
	logic                         dbg_ready;
	logic [csr_pkg::CSR_AW-1:0]   dbg_addr;
	logic                         dbg_wen;
	logic [csr_pkg::XLEN-1:0]     dbg_wdata;
	logic                         dbg_rsp_valid;
	logic [csr_pkg::XLEN-1:0]     dbg_rdata;
	logic                         wb_valid;
	logic [csr_pkg::PRF_AW-1:0]   wb_rd;
	logic [csr_pkg::XLEN-1:0]     wb_data;

	logic [csr_pkg::XLEN-1:0]     m_mstatus;          // Model of the writable CSRs
	logic [csr_pkg::XLEN-1:0]     m_mtvec;
	logic [csr_pkg::XLEN-1:0]     m_mscratch;
	logic [csr_pkg::XLEN-1:0]     m_mepc;
	logic [csr_pkg::XLEN-1:0]     m_mcause;
	logic [csr_pkg::XLEN-1:0]     prf_model [csr_pkg::PRF_NUM];  // Expected register contents

	clk_gen #(.PERIOD(PERIOD)) u_clk (.CLK(CLK));

	csr_unit_top dut0 (.*);

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input string name, input logic [csr_pkg::XLEN-1:0] got,
			input logic [csr_pkg::XLEN-1:0] exp);
		if (got !== exp) begin
			report_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_tag(input string name, input logic [csr_pkg::PRF_AW-1:0] got,
			input logic [csr_pkg::PRF_AW-1:0] exp);
		if (got !== exp) begin
			report_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
		end
	endtask

	function automatic logic [csr_pkg::XLEN-1:0] rand64();
		return {$urandom(), $urandom()};
	endfunction

	// Reference read, misa is fixed and anything unimplemented reads zero
	function automatic logic [csr_pkg::XLEN-1:0] model_read(input logic [csr_pkg::CSR_AW-1:0] addr);
		case (addr)
			csr_pkg::ADDR_MSTATUS:  return m_mstatus;
			csr_pkg::ADDR_MISA:     return csr_pkg::MISA_VALUE;
			csr_pkg::ADDR_MTVEC:    return m_mtvec;
			csr_pkg::ADDR_MSCRATCH: return m_mscratch;
			csr_pkg::ADDR_MEPC:     return m_mepc;
			csr_pkg::ADDR_MCAUSE:   return m_mcause;
			default:                return '0;
		endcase
	endfunction

	task automatic model_write(input logic [csr_pkg::CSR_AW-1:0] addr,
			input logic [csr_pkg::XLEN-1:0] val);
		case (addr)
			csr_pkg::ADDR_MSTATUS:  m_mstatus  = val & csr_pkg::MSTATUS_WMASK;
			csr_pkg::ADDR_MTVEC:    m_mtvec    = val & csr_pkg::MTVEC_WMASK;
			csr_pkg::ADDR_MSCRATCH: m_mscratch = val;
			csr_pkg::ADDR_MEPC:     m_mepc     = val & csr_pkg::MEPC_WMASK;
			csr_pkg::ADDR_MCAUSE:   m_mcause   = val;
			default:                m_mcause   = m_mcause;  // misa and unknown drop the write
		endcase
	endtask

	// Immediate forms carry a 5-bit value in the low bits of the rs1 field
	function automatic logic [csr_pkg::XLEN-1:0] operand_of(input logic imm,
			input logic [csr_pkg::PRF_AW-1:0] rs1);
		if (imm) begin
			return {{(csr_pkg::XLEN - 5){1'b0}}, rs1[4:0]};
		end
		return prf_model[rs1];
	endfunction

	function automatic logic [csr_pkg::XLEN-1:0] rmw_value(input csr_pkg::csr_op_t op,
			input logic [csr_pkg::XLEN-1:0] old, input logic [csr_pkg::XLEN-1:0] operand);
		case (op)
			csr_pkg::CSR_RW: return operand;
			csr_pkg::CSR_RS: return old | operand;
			csr_pkg::CSR_RC: return old & ~operand;
			default:         return old;
		endcase
	endfunction

	task automatic drive_issue(input csr_pkg::csr_op_t op, input logic imm,
			input logic [csr_pkg::PRF_AW-1:0] rs1, input logic [csr_pkg::PRF_AW-1:0] rd,
			input logic [csr_pkg::CSR_AW-1:0] addr);
		issue_valid = 1'b1;
		issue_op    = op;
		issue_imm   = imm;
		issue_rs1   = rs1;
		issue_rd    = rd;
		issue_addr  = addr;
	endtask

	// Called at the sample point of a cycle where the issue port is already driven
	task automatic complete_issue(input csr_pkg::csr_op_t op, input logic imm,
			input logic [csr_pkg::PRF_AW-1:0] rs1, input logic [csr_pkg::PRF_AW-1:0] rd,
			input logic [csr_pkg::CSR_AW-1:0] addr);
		int                       waited;
		logic [csr_pkg::XLEN-1:0] operand;
		logic [csr_pkg::XLEN-1:0] old;
		waited = 0;
		while (issue_ready !== 1'b1) begin
			waited++;
			if (waited > STALL_LIMIT) begin
				report_error("issue_ready stayed low, the instruction was never accepted");
			end
			@(negedge CLK);
			#SETTLE;
		end
		operand = operand_of(imm, rs1);
		old     = model_read(addr);
		if (op == csr_pkg::CSR_RW || operand != '0) begin
			model_write(addr, rmw_value(op, old, operand));  // Zero set or clear makes no write
		end
		@(negedge CLK);
		issue_valid = 1'b0;
		#SETTLE;
		if (rd != '0) begin
			check_flag("wb_valid", wb_valid, 1'b1);
			check_tag("wb_rd", wb_rd, rd);
			check_data("wb_data", wb_data, old);       // Value from before the update
			prf_model[rd] = old;
		end else begin
			check_flag("wb_valid", wb_valid, 1'b0);
		end
		@(negedge CLK);
		#SETTLE;
		check_flag("wb_valid", wb_valid, 1'b0);        // Writeback lasts a single cycle
	endtask

	task automatic run_issue(input csr_pkg::csr_op_t op, input logic imm,
			input logic [csr_pkg::PRF_AW-1:0] rs1, input logic [csr_pkg::PRF_AW-1:0] rd,
			input logic [csr_pkg::CSR_AW-1:0] addr);
		@(negedge CLK);
		drive_issue(op, imm, rs1, rd, addr);
		#SETTLE;
		complete_issue(op, imm, rs1, rd, addr);
	endtask

	task automatic preload(input logic [csr_pkg::PRF_AW-1:0] tag,
			input logic [csr_pkg::XLEN-1:0] data);
		@(negedge CLK);
		pre_valid = 1'b1;
		pre_tag   = tag;
		pre_data  = data;
		@(negedge CLK);
		pre_valid = 1'b0;
		#SETTLE;
		prf_model[tag] = data;
	endtask

	task automatic dbg_access(input logic [csr_pkg::CSR_AW-1:0] addr, input logic wen,
			input logic [csr_pkg::XLEN-1:0] wdata, output logic [csr_pkg::XLEN-1:0] rdata);
		@(negedge CLK);
		dbg_valid = 1'b1;
		dbg_addr  = addr;
		dbg_wen   = wen;
		dbg_wdata = wdata;
		#SETTLE;
		check_flag("dbg_ready", dbg_ready, 1'b1);
		@(negedge CLK);
		dbg_valid = 1'b0;
		dbg_wen   = 1'b0;
		#SETTLE;
		check_flag("dbg_rsp_valid", dbg_rsp_valid, 1'b1);  // One cycle after the transfer
		rdata = dbg_rdata;
	endtask

	task automatic dbg_read(input logic [csr_pkg::CSR_AW-1:0] addr);
		logic [csr_pkg::XLEN-1:0] rdata;
		dbg_access(addr, 1'b0, '0, rdata);
		check_data("dbg_rdata", rdata, model_read(addr));
	endtask

	task automatic dbg_write(input logic [csr_pkg::CSR_AW-1:0] addr,
			input logic [csr_pkg::XLEN-1:0] data);
		logic [csr_pkg::XLEN-1:0] rdata;
		dbg_access(addr, 1'b1, data, rdata);
		check_data("dbg_rdata", rdata, model_read(addr));  // Old value comes back
		model_write(addr, data);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (RESET_CYC) @(negedge CLK);
		rst        = 1'b0;
		m_mstatus  = '0;
		m_mtvec    = '0;
		m_mscratch = '0;
		m_mepc     = '0;
		m_mcause   = '0;
		#SETTLE;
		check_flag("wb_valid", wb_valid, 1'b0);
		check_flag("dbg_rsp_valid", dbg_rsp_valid, 1'b0);
		check_flag("issue_ready", issue_ready, 1'b1);
	endtask

	// Tag 10 gets the old mscratch and tag 11 feeds the third write back in
	task automatic test_csrrw();
		for (int t = 1; t <= 8; t++) begin
			preload(t[csr_pkg::PRF_AW-1:0], rand64());
		end
		preload(9, '1);                                // All ones for the mask test
		preload(14, rand64());                         // Must survive the flush test
		run_issue(csr_pkg::CSR_RW, 1'b0, 1, 10, csr_pkg::ADDR_MSCRATCH);
		dbg_read(csr_pkg::ADDR_MSCRATCH);
		run_issue(csr_pkg::CSR_RW, 1'b0, 2, 11, csr_pkg::ADDR_MSCRATCH);
		run_issue(csr_pkg::CSR_RW, 1'b0, 11, 12, csr_pkg::ADDR_MSCRATCH);
		dbg_read(csr_pkg::ADDR_MSCRATCH);
	endtask

	task automatic test_set_clear();
		run_issue(csr_pkg::CSR_RS, 1'b0, 3, 20, csr_pkg::ADDR_MSCRATCH);
		dbg_read(csr_pkg::ADDR_MSCRATCH);
		run_issue(csr_pkg::CSR_RC, 1'b0, 4, 21, csr_pkg::ADDR_MSCRATCH);
		dbg_read(csr_pkg::ADDR_MSCRATCH);
		run_issue(csr_pkg::CSR_RS, 1'b1, 6'h15, 22, csr_pkg::ADDR_MCAUSE);
		dbg_read(csr_pkg::ADDR_MCAUSE);
		run_issue(csr_pkg::CSR_RC, 1'b1, 6'h05, 23, csr_pkg::ADDR_MCAUSE);
		dbg_read(csr_pkg::ADDR_MCAUSE);
		run_issue(csr_pkg::CSR_RS, 1'b0, 0, 24, csr_pkg::ADDR_MSCRATCH);  // Zero from tag 0
		dbg_read(csr_pkg::ADDR_MSCRATCH);
		run_issue(csr_pkg::CSR_RC, 1'b1, 6'h00, 25, csr_pkg::ADDR_MCAUSE);
		dbg_read(csr_pkg::ADDR_MCAUSE);
	endtask

	task automatic test_masks();
		run_issue(csr_pkg::CSR_RW, 1'b0, 9, 16, csr_pkg::ADDR_MSTATUS);
		dbg_read(csr_pkg::ADDR_MSTATUS);
		run_issue(csr_pkg::CSR_RC, 1'b1, 6'h08, 16, csr_pkg::ADDR_MSTATUS);  // Clear MIE
		dbg_read(csr_pkg::ADDR_MSTATUS);
		run_issue(csr_pkg::CSR_RW, 1'b0, 9, 17, csr_pkg::ADDR_MTVEC);
		dbg_read(csr_pkg::ADDR_MTVEC);
		run_issue(csr_pkg::CSR_RW, 1'b0, 9, 18, csr_pkg::ADDR_MEPC);
		dbg_read(csr_pkg::ADDR_MEPC);
		run_issue(csr_pkg::CSR_RW, 1'b0, 9, 19, csr_pkg::ADDR_MISA);
		dbg_read(csr_pkg::ADDR_MISA);
		run_issue(csr_pkg::CSR_RW, 1'b0, 9, 26, ADDR_UNKNOWN);
		dbg_read(ADDR_UNKNOWN);
		dbg_write(csr_pkg::ADDR_MTVEC, rand64());
		dbg_read(csr_pkg::ADDR_MTVEC);
	endtask

	// Debug holds the port for three cycles while an instruction waits
	task automatic test_debug_priority();
		@(negedge CLK);
		dbg_valid = 1'b1;
		dbg_addr  = csr_pkg::ADDR_MSCRATCH;
		dbg_wen   = 1'b0;
		drive_issue(csr_pkg::CSR_RW, 1'b0, 6, 13, csr_pkg::ADDR_MSCRATCH);
		for (int i = 0; i < 3; i++) begin
			#SETTLE;
			check_flag("issue_ready", issue_ready, 1'b0);
			check_flag("dbg_ready", dbg_ready, 1'b1);
			check_flag("dbg_rsp_valid", dbg_rsp_valid, i > 0);
			if (i > 0) begin
				check_data("dbg_rdata", dbg_rdata, model_read(csr_pkg::ADDR_MSCRATCH));
			end
			@(negedge CLK);
		end
		dbg_valid = 1'b0;
		#SETTLE;
		check_flag("dbg_rsp_valid", dbg_rsp_valid, 1'b1);
		check_flag("issue_ready", issue_ready, 1'b1);
		complete_issue(csr_pkg::CSR_RW, 1'b0, 6, 13, csr_pkg::ADDR_MSCRATCH);
		dbg_read(csr_pkg::ADDR_MSCRATCH);
	endtask

	task automatic test_rd_zero();
		run_issue(csr_pkg::CSR_RW, 1'b0, 7, 0, csr_pkg::ADDR_MCAUSE);
		dbg_read(csr_pkg::ADDR_MCAUSE);
	endtask

	task automatic test_flush_reset();
		logic [csr_pkg::XLEN-1:0] first;
		logic [csr_pkg::XLEN-1:0] second;
		@(negedge CLK);
		drive_issue(csr_pkg::CSR_RW, 1'b0, 8, 14, csr_pkg::ADDR_MSCRATCH);
		#SETTLE;
		check_flag("issue_ready", issue_ready, 1'b1);
		model_write(csr_pkg::ADDR_MSCRATCH, prf_model[8]);  // CSR write stays, tag 14 does not
		@(negedge CLK);
		issue_valid = 1'b0;
		flush       = 1'b1;
		#SETTLE;
		check_flag("wb_valid", wb_valid, 1'b0);
		@(negedge CLK);
		flush = 1'b0;
		#SETTLE;
		check_flag("wb_valid", wb_valid, 1'b0);
		dbg_read(csr_pkg::ADDR_MSCRATCH);
		run_issue(csr_pkg::CSR_RW, 1'b0, 14, 15, csr_pkg::ADDR_MSCRATCH);
		dbg_read(csr_pkg::ADDR_MSCRATCH);
		dbg_access(csr_pkg::ADDR_MCYCLE, 1'b0, '0, first);
		@(negedge CLK);
		drive_issue(csr_pkg::CSR_RS, 1'b0, 0, 27, csr_pkg::ADDR_MCYCLE);  // Set with zero
		#SETTLE;
		check_flag("issue_ready", issue_ready, 1'b1);
		@(negedge CLK);
		issue_valid = 1'b0;
		#SETTLE;
		check_flag("wb_valid", wb_valid, 1'b1);
		check_tag("wb_rd", wb_rd, 27);
		check_data("wb_data", wb_data, first + 2);    // Two edges after the first read
		prf_model[27] = first + 2;
		@(negedge CLK);
		dbg_access(csr_pkg::ADDR_MCYCLE, 1'b0, '0, second);
		check_data("mcycle", second, first + MCYCLE_STEP);  // A write would have held it once
		@(negedge CLK);
		apply_reset();
		dbg_read(csr_pkg::ADDR_MSCRATCH);
	endtask

	initial begin
		#(TEST_CYC * MARGIN * PERIOD);
		report_error("Watchdog timeout, the tests did not finish in time");
	end

	initial begin
		rst         = 1'b1;
		flush       = 1'b0;
		issue_valid = 1'b0;
		issue_op    = csr_pkg::CSR_RW;
		issue_imm   = 1'b0;
		issue_rs1   = '0;
		issue_rd    = '0;
		issue_addr  = '0;
		pre_valid   = 1'b0;
		pre_tag     = '0;
		pre_data    = '0;
		dbg_valid   = 1'b0;
		dbg_addr    = '0;
		dbg_wen     = 1'b0;
		dbg_wdata   = '0;
		void'($urandom(SEED));
		for (int t = 0; t < csr_pkg::PRF_NUM; t++) begin
			prf_model[t] = '0;
		end
		apply_reset();
		test_csrrw();
		test_set_clear();
		test_masks();
		test_debug_priority();
		test_rd_zero();
		test_flush_reset();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/csr_pkg.sv
design/csr_file.sv
design/csr_arbiter.sv
design/csr_exe.sv
design/phy_regfile.sv
design/csr_unit_top.sv
verif/clk_gen.sv
verif/tb_csr_unit.sv

// ==== run.sh ====
#!/bin/sh
# Builds the CSR slice testbench with Verilator, runs it and scans the log
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing -Wno-fatal --top-module tb_csr_unit -f filelist.f \
	-o sim_csr_unit > "$LOG" 2>&1 \
	&& ./obj_dir/sim_csr_unit >> "$LOG" 2>&1 \
	|| echo "Checks failed" >> "$LOG"
cat "$LOG"
grep -q "Checks failed" "$LOG" && echo "Simulation FAILED" && exit 1
echo "Simulation PASSED"
exit 0
